/* audio_pkg.sv */
package audio_pkg;

    //////////////////////////////////////////////////
    // Sample format
    //////////////////////////////////////////////////

    localparam int SAMPLE_WIDTH = 16;

    // One signed audio sample
    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

    // Sample inside a frame, last marks the final one
    typedef struct packed {
        sample_t data;
        logic    last;
    } frame_sample_t;

    //////////////////////////////////////////////////
    // Taper arithmetic
    //////////////////////////////////////////////////

    // Window coefficient, 32768 is unity gain
    typedef logic [SAMPLE_WIDTH:0] coef_t;

    // Product shift that brings the coefficient back to unity
    localparam int TAPER_SHIFT = 15;

endpackage

/* band_energy.sv */
`timescale 1ns/100ps

module band_energy
    import audio_pkg::*;
    import feature_pkg::*;
#(
    parameter int N = 64
) (
    input  logic          clk,
    input  logic          reset,
    input  frame_sample_t in_frame,
    input  logic          in_valid,
    output logic          in_ready,
    output band_vector_t  out_bands,
    output logic          out_valid,
    input  logic          out_ready
);

    localparam int SEG_LEN = N / NUM_BANDS;
    localparam int SW      = (SEG_LEN > 1) ? $clog2(SEG_LEN) : 1;
    localparam int BW      = $clog2(NUM_BANDS);

    logic [31:0]    acc;
    logic [31:0]    square;
    logic [32:0]    sum_wide;
    logic [31:0]    acc_next;
    band_energy_t   energy;
    logic [SW-1:0]  seg_count;
    logic [BW-1:0]  band_idx;
    logic           seg_done;
    logic           in_fire;

    // Finished vector blocks new samples until sent
    assign in_ready = !out_valid;
    assign in_fire  = in_valid && in_ready;
    assign seg_done = (seg_count == SW'(SEG_LEN - 1));

    assign square   = 32'(in_frame.data) * 32'(in_frame.data);
    assign sum_wide = {1'b0, acc} + {1'b0, square};
    // Sum clamps at the top of the 32-bit range
    assign acc_next = sum_wide[32] ? '1 : sum_wide[31:0];
    // A clamped sum scales to the 65535 ceiling
    assign energy   = band_energy_t'(acc_next >> ENERGY_SHIFT);

    always_ff @(posedge clk) begin
        if (reset) begin
            acc       <= '0;
            seg_count <= '0;
            band_idx  <= '0;
            out_valid <= 1'b0;
        end else begin
            if (in_fire) begin
                acc       <= seg_done ? '0 : acc_next;
                seg_count <= seg_done ? '0 : seg_count + 1'b1;
                if (seg_done) begin
                    band_idx <= band_idx + 1'b1;
                end
                if (in_frame.last) begin
                    seg_count <= '0;
                    band_idx  <= '0;
                    out_valid <= 1'b1;
                end
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire && seg_done) begin
            out_bands[band_idx] <= energy;
        end
    end

endmodule

/* band_energy_frontend.sv */
`timescale 1ns/100ps

module band_energy_frontend
    import audio_pkg::*;
    import feature_pkg::*;
#(
    parameter int N         = 64,
    parameter int STRIDE    = 32,
    parameter int OUT_WIDTH = 2
) (
    input  logic         clk,
    input  logic         reset,
    input  sample_t      in_data,
    input  logic         in_valid,
    output logic         in_ready,
    output band_energy_t out_data [OUT_WIDTH],
    output logic         out_valid,
    output logic         out_last,
    input  logic         out_ready
);

    frame_sample_t frame_data, taper_data, fifo_frame;
    logic          frame_valid, frame_ready;
    logic          taper_valid, taper_ready;
    logic          fifo_frame_valid, fifo_frame_ready;
    band_vector_t  bands, fifo_bands;
    logic          bands_valid, bands_ready;
    logic          fifo_bands_valid, fifo_bands_ready;

    //////////////////////////////////////////////////
    // Producer
    //////////////////////////////////////////////////

    frame_builder #(.N(N), .STRIDE(STRIDE)) frame_builder_i (
        .clk(clk), .reset(reset),
        .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
        .out_frame(frame_data), .out_valid(frame_valid), .out_ready(frame_ready)
    );

    window_taper #(.N(N)) window_taper_i (
        .clk(clk), .reset(reset),
        .in_frame(frame_data), .in_valid(frame_valid), .in_ready(frame_ready),
        .out_frame(taper_data), .out_valid(taper_valid), .out_ready(taper_ready)
    );

    stream_fifo #(.payload_t(frame_sample_t), .FIFO_DEPTH(4)) sample_fifo_i (
        .clk(clk), .reset(reset),
        .in_data(taper_data), .in_valid(taper_valid), .in_ready(taper_ready),
        .out_data(fifo_frame), .out_valid(fifo_frame_valid), .out_ready(fifo_frame_ready)
    );

    //////////////////////////////////////////////////
    // Consumer
    //////////////////////////////////////////////////

    band_energy #(.N(N)) band_energy_i (
        .clk(clk), .reset(reset),
        .in_frame(fifo_frame), .in_valid(fifo_frame_valid), .in_ready(fifo_frame_ready),
        .out_bands(bands), .out_valid(bands_valid), .out_ready(bands_ready)
    );

    stream_fifo #(.payload_t(band_vector_t), .FIFO_DEPTH(4)) band_fifo_i (
        .clk(clk), .reset(reset),
        .in_data(bands), .in_valid(bands_valid), .in_ready(bands_ready),
        .out_data(fifo_bands), .out_valid(fifo_bands_valid), .out_ready(fifo_bands_ready)
    );

    feature_serializer #(.OUT_WIDTH(OUT_WIDTH)) feature_serializer_i (
        .clk(clk), .reset(reset),
        .in_bands(fifo_bands), .in_valid(fifo_bands_valid), .in_ready(fifo_bands_ready),
        .out_data(out_data), .out_valid(out_valid), .out_last(out_last),
        .out_ready(out_ready)
    );

endmodule

/* feature_pkg.sv */
package feature_pkg;

    //////////////////////////////////////////////////
    // Band layout
    //////////////////////////////////////////////////

    // Equal time segments per frame
    localparam int NUM_BANDS = 8;

    // Scaling of a segment sum before saturation
    localparam int ENERGY_SHIFT = 16;

    //////////////////////////////////////////////////
    // Energy types
    //////////////////////////////////////////////////

    typedef logic [15:0] band_energy_t;

    // Band 0 sits in the low bits
    typedef band_energy_t [NUM_BANDS-1:0] band_vector_t;

endpackage

/* feature_serializer.sv */
`timescale 1ns/100ps

module feature_serializer
    import feature_pkg::*;
#(
    parameter int OUT_WIDTH = 2
) (
    input  logic         clk,
    input  logic         reset,
    input  band_vector_t in_bands,
    input  logic         in_valid,
    output logic         in_ready,
    output band_energy_t out_data [OUT_WIDTH],
    output logic         out_valid,
    output logic         out_last,
    input  logic         out_ready
);

    localparam int NUM_BEATS = NUM_BANDS / OUT_WIDTH;
    localparam int BW        = (NUM_BEATS > 1) ? $clog2(NUM_BEATS) : 1;

    band_vector_t  vec;
    logic [BW-1:0] beat;

    assign in_ready = !out_valid;
    assign out_last = out_valid && (beat == BW'(NUM_BEATS - 1));

    // Slice of the held vector for the current beat
    always_comb begin
        for (int i = 0; i < OUT_WIDTH; i++) begin
            out_data[i] = vec[int'(beat) * OUT_WIDTH + i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            beat      <= '0;
            out_valid <= 1'b0;
        end else begin
            if (in_valid && in_ready) begin
                out_valid <= 1'b1;
                beat      <= '0;
            end else if (out_valid && out_ready) begin
                beat <= out_last ? '0 : beat + 1'b1;
                if (out_last) begin
                    out_valid <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            vec <= in_bands;
        end
    end

endmodule

/* files.f */
audio_pkg.sv
feature_pkg.sv
frame_builder.sv
window_taper.sv
stream_fifo.sv
band_energy.sv
feature_serializer.sv
band_energy_frontend.sv
tb_band_energy_frontend.sv

/* frame_builder.sv */
`timescale 1ns/100ps

module frame_builder
    import audio_pkg::*;
#(
    parameter int N      = 64,
    parameter int STRIDE = 32
) (
    input  logic          clk,
    input  logic          reset,
    input  sample_t       in_data,
    input  logic          in_valid,
    output logic          in_ready,
    output frame_sample_t out_frame,
    output logic          out_valid,
    input  logic          out_ready
);

    localparam int PW = $clog2(N);

    // Circular sample history
    sample_t mem [N];

    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_idx;
    logic [PW-1:0] rd_addr;
    logic [PW:0]   fill_count;
    logic          replaying;
    logic          in_fire;
    logic          out_fire;

    assign in_ready  = !replaying;
    assign out_valid = replaying;
    assign in_fire   = in_valid && in_ready;
    assign out_fire  = out_valid && out_ready;

    // Oldest sample sits at the write pointer, the sum wraps mod N
    assign rd_addr = wr_ptr + rd_idx;

    assign out_frame.data = mem[rd_addr];
    assign out_frame.last = (rd_idx == PW'(N - 1));

    always_ff @(posedge clk) begin
        if (in_fire) begin
            mem[wr_ptr] <= in_data;
        end
    end

    //////////////////////////////////////////////////
    // Fill and replay control
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_idx     <= '0;
            fill_count <= '0;
            replaying  <= 1'b0;
        end else begin
            if (in_fire) begin
                wr_ptr     <= wr_ptr + 1'b1;
                fill_count <= fill_count + 1'b1;
                // Store full after this write
                if (fill_count == (PW+1)'(N - 1)) begin
                    replaying <= 1'b1;
                end
            end
            if (out_fire) begin
                rd_idx <= rd_idx + 1'b1;
                if (out_frame.last) begin
                    replaying <= 1'b0;
                    // Keep the overlap, wait for STRIDE fresh samples
                    fill_count <= (PW+1)'(N - STRIDE);
                end
            end
        end
    end

endmodule

/* stream_fifo.sv */
`timescale 1ns/100ps

module stream_fifo #(
    parameter type payload_t  = logic [7:0],
    parameter int  FIFO_DEPTH = 8
) (
    input  logic     clk,
    input  logic     reset,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    payload_t mem [FIFO_DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          wr_en;
    logic          rd_en;

    assign in_ready  = (count < CW'(FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign wr_en     = in_valid && in_ready;
    assign rd_en     = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // Pointers wrap at the depth, which need not be a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(wr_en) - CW'(rd_en);
        end
    end

endmodule

/* tb_band_energy_frontend.sv */
`timescale 1ns/100ps

module tb_band_energy_frontend
    import audio_pkg::*;
    import feature_pkg::*;
();

    localparam int N         = 64;
    localparam int STRIDE    = 32;
    localparam int OUT_WIDTH = 2;
    localparam int NUM_BEATS = NUM_BANDS / OUT_WIDTH;
    localparam int SEG_LEN   = N / NUM_BANDS;
    localparam int MAX_K     = 256;

    // Sum of the sample counts of the six tests
    localparam int TOTAL_SAMPLES = 64 + 237 + 128 + 160 + 160 + 64;
    localparam int MAX_CYCLES    = 4 * TOTAL_SAMPLES + 2000;

    logic         clk;
    logic         reset;
    sample_t      in_data;
    logic         in_valid;
    logic         in_ready;
    band_energy_t out_data [OUT_WIDTH];
    logic         out_valid;
    logic         out_last;
    logic         out_ready;

    sample_t      stim [MAX_K];
    band_vector_t exp_q [$];
    band_vector_t rx_log [$];
    band_vector_t baseline [$];
    band_vector_t rx_vec;
    band_vector_t exp_vec;
    logic         ready_pattern [256];
    logic         bp_on;
    integer       seed;
    int           cycle;
    int           beat_idx;
    int           frames_rx;
    int           errors;
    int           tests_failed;
    int           start_errors;

    band_energy_frontend band_energy_frontend_i (
        .clk(clk), .reset(reset),
        .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
        .out_data(out_data), .out_valid(out_valid), .out_last(out_last),
        .out_ready(out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Watchdog
    initial begin
        cycle = 0;
        while (cycle < MAX_CYCLES) begin
            @(posedge clk);
            cycle++;
        end
        $display("The run timed out after %0d cycles without finishing its tests", cycle);
        $display("Simulation failed");
        $finish;
    end

    // Output back-pressure from a precomputed pattern
    initial begin
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            out_ready = bp_on ? ready_pattern[cycle % 256] : 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic int frames_for(input int k);
        return (k < N) ? 0 : 1 + (k - N) / STRIDE;
    endfunction

    // Triangular taper, square, segment sums, scale and saturate
    function automatic band_vector_t expected_bands(input sample_t frame [N]);
        band_vector_t bands;
        longint       sum;
        longint       coef;
        longint       tapered;
        int           n;
        int           ramp;
        for (int b = 0; b < NUM_BANDS; b++) begin
            sum = 0;
            for (int k = 0; k < SEG_LEN; k++) begin
                n = b * SEG_LEN + k;
                ramp = ((n < N - 1 - n) ? n : N - 1 - n) + 1;
                coef = ramp * (65536 / N);
                tapered = (longint'(frame[n]) * coef) >>> 15;
                sum += tapered * tapered;
            end
            sum = sum >> ENERGY_SHIFT;
            bands[b] = (sum > 65535) ? 16'hffff : band_energy_t'(sum);
        end
        return bands;
    endfunction

    //////////////////////////////////////////////////
    // Output collection and comparison
    //////////////////////////////////////////////////

    // Sampled mid-cycle so a beat seen here transfers on the next rising edge
    always @(negedge clk) begin
        if (reset) begin
            beat_idx = 0;
        end else if (out_valid && out_ready) begin
            if (beat_idx >= NUM_BEATS) begin
                $display("ERROR at %0t: beat %0d exceeds the beats of one frame", $time, beat_idx);
                errors++;
                beat_idx = 0;
            end
            if (out_last != (beat_idx == NUM_BEATS - 1)) begin
                $display("ERROR at %0t: out_last is %0b on beat %0d", $time, out_last, beat_idx);
                errors++;
            end
            for (int i = 0; i < OUT_WIDTH; i++) begin
                rx_vec[beat_idx * OUT_WIDTH + i] = out_data[i];
            end
            beat_idx++;
            if (out_last) begin
                beat_idx = 0;
                if (exp_q.size() == 0) begin
                    $display("A frame came out at %0t that no input frame accounts for", $time);
                    errors++;
                end else begin
                    exp_vec = exp_q.pop_front();
                    for (int b = 0; b < NUM_BANDS; b++) begin
                        if (rx_vec[b] != exp_vec[b]) begin
                            $display("ERROR at %0t: frame %0d band %0d is %0d, expected %0d",
                                     $time, frames_rx, b, rx_vec[b], exp_vec[b]);
                            errors++;
                        end
                    end
                end
                rx_log.push_back(rx_vec);
                frames_rx++;
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    // Drives one sample and reports whether in_ready held it back
    task automatic send_sample(input sample_t value, input int gap, output bit waited);
        waited = 1'b0;
        if (gap > 0) begin
            in_valid = 1'b0;
            repeat (gap) @(posedge clk);
            #1;
        end
        in_data  = value;
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready) begin
            waited = 1'b1;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic fill_random(input int count);
        for (int i = 0; i < count; i++) begin
            stim[i] = sample_t'($random(seed));
        end
    endtask

    task automatic run_test(input int count, input bit gaps, input bit stall);
        sample_t frame [N];
        int      n_frames;
        int      gap;
        bit      waited;
        in_valid = 1'b0;
        reset    = 1'b1;
        bp_on    = stall;
        for (int i = 0; i < 256; i++) begin
            ready_pattern[i] = ($unsigned($random(seed)) % 4) != 0;
        end
        exp_q.delete();
        rx_log.delete();
        frames_rx = 0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        n_frames = frames_for(count);
        for (int f = 0; f < n_frames; f++) begin
            for (int i = 0; i < N; i++) begin
                frame[i] = stim[f * STRIDE + i];
            end
            exp_q.push_back(expected_bands(frame));
        end
        for (int i = 0; i < count; i++) begin
            gap = 0;
            if (gaps && ($unsigned($random(seed)) % 4 == 0)) begin
                gap = 1 + $unsigned($random(seed)) % 3;
            end
            send_sample(stim[i], gap, waited);
            // Store is full before sample N and every STRIDE samples after it
            if (waited != ((i >= N) && ((i - N) % STRIDE == 0))) begin
                $display("ERROR at %0t: in_ready was %s before sample %0d", $time,
                         waited ? "low" : "high", i);
                errors++;
            end
        end
        in_valid = 1'b0;
        while (frames_rx < n_frames) begin
            @(posedge clk);
        end
        // Drain long enough for surplus frames to show up
        repeat (100) @(posedge clk);
        #1;
        if (frames_rx != n_frames || exp_q.size() != 0) begin
            $display("Frame count is wrong: %0d frames came out, %0d were expected",
                     frames_rx, n_frames);
            errors++;
        end
        bp_on = 1'b0;
    endtask

    task automatic report_test(input int num, input string name);
        if (errors == start_errors) begin
            $display("Test %0d (%s): PASS, %0d frames", num, name, frames_rx);
        end else begin
            $display("Test %0d (%s): FAIL, %0d errors", num, name, errors - start_errors);
            tests_failed++;
        end
    endtask

    initial begin
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_data   = '0;
        bp_on     = 1'b0;
        seed      = 32'h8e91;
        errors    = 0;
        frames_rx = 0;
        tests_failed = 0;

        // Ramp of exactly one frame
        start_errors = errors;
        for (int i = 0; i < N; i++) begin
            stim[i] = sample_t'(i * 512 - 16384);
        end
        run_test(N, 1'b0, 1'b0);
        report_test(1, "ramp frame");

        start_errors = errors;
        fill_random(237);
        run_test(237, 1'b0, 1'b0);
        report_test(2, "frame overlap");

        start_errors = errors;
        fill_random(128);
        run_test(128, 1'b0, 1'b0);
        report_test(3, "beat structure");

        start_errors = errors;
        fill_random(160);
        run_test(160, 1'b0, 1'b1);
        baseline = rx_log;
        report_test(4, "output back-pressure");

        // Same samples again with input gaps
        start_errors = errors;
        run_test(160, 1'b1, 1'b0);
        if (rx_log.size() != baseline.size()) begin
            $display("The run with input gaps gave %0d frames, the run without gave %0d",
                     rx_log.size(), baseline.size());
            errors++;
        end else begin
            for (int f = 0; f < rx_log.size(); f++) begin
                if (rx_log[f] != baseline[f]) begin
                    $display("ERROR at %0t: frame %0d differs from the run without gaps",
                             $time, f);
                    errors++;
                end
            end
        end
        report_test(5, "input gaps");

        // Alternating full-scale samples clip the centre bands
        start_errors = errors;
        for (int i = 0; i < N; i++) begin
            stim[i] = (i % 2 == 0) ? 16'sh7fff : 16'sh8000;
        end
        run_test(N, 1'b0, 1'b0);
        if (rx_log.size() == 1) begin
            if (rx_log[0][NUM_BANDS/2 - 1] != 16'hffff || rx_log[0][NUM_BANDS/2] != 16'hffff) begin
                $display("ERROR at %0t: centre bands %0d and %0d did not saturate", $time,
                         rx_log[0][NUM_BANDS/2 - 1], rx_log[0][NUM_BANDS/2]);
                errors++;
            end
        end
        report_test(6, "full-scale saturation");

        $display("Tests run: 6, tests failed: %0d, errors: %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* window_taper.sv */
`timescale 1ns/100ps

module window_taper
    import audio_pkg::*;
#(
    parameter int N = 64
) (
    input  logic          clk,
    input  logic          reset,
    input  frame_sample_t in_frame,
    input  logic          in_valid,
    output logic          in_ready,
    output frame_sample_t out_frame,
    output logic          out_valid,
    input  logic          out_ready
);

    localparam int PW        = $clog2(N);
    localparam int COEF_STEP = 65536 / N;

    logic [PW-1:0]      pos;
    logic [PW-1:0]      mirror;
    logic [PW-1:0]      ramp;
    coef_t              coef;
    logic signed [33:0] product;
    sample_t            tapered;
    logic               in_fire;

    // Single stage, refills while draining
    assign in_ready = !out_valid || out_ready;
    assign in_fire  = in_valid && in_ready;

    // Triangle peak at the frame centre
    assign mirror  = ~pos;
    assign ramp    = ((pos < mirror) ? pos : mirror) + 1'b1;
    assign coef    = coef_t'(ramp) * coef_t'(COEF_STEP);
    assign product = in_frame.data * $signed({1'b0, coef});
    assign tapered = sample_t'(product >>> TAPER_SHIFT);

    always_ff @(posedge clk) begin
        if (reset) begin
            pos       <= '0;
            out_valid <= 1'b0;
        end else begin
            if (in_fire) begin
                pos       <= in_frame.last ? '0 : pos + 1'b1;
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            out_frame.data <= tapered;
            out_frame.last <= in_frame.last;
        end
    end

endmodule
